// File: sources.f
+incdir+verilog
verilog/gfp_fetch_pkg.sv
verilog/fetch_cmd_decode.sv
verilog/burst_reader.sv
verilog/exp_unpacker.sv
verilog/gfp_fetcher.sv
tests/tb_gfp_fetcher.sv

// File: tests/tb_gfp_fetcher.sv
// Testbench for the GFP8 block fetcher with memory, buffer and reference models and compare tasks
`default_nettype none

`include "gfp_fetch_params.svh"

module tb_gfp_fetcher
    import gfp_fetch_pkg::*;
();

    localparam int NUM_CMDS   = 6;
    // Stalls cost at most about 5 cycles per line and 8 leaves room
    localparam int MAX_CYCLES = NUM_CMDS * `GFP_BLOCK_LINES * 8 + 2000;
    localparam int REQS       = `GFP_BLOCK_LINES / `GFP_BURST_BEATS;
    localparam int EXPS       = `GFP_EXP_LINES * `GFP_EXP_PER_LINE;

    logic                        i_clk;
    logic                        i_reset_n;
    logic                        i_cmd_valid;
    logic                        o_cmd_ready;
    fetch_cmd_t                  i_cmd;
    logic                        o_req_valid;
    logic                        i_req_ready;
    rd_req_t                     o_req;
    logic                        i_beat_valid;
    logic                        o_beat_ready;
    rd_beat_t                    i_beat;
    buf_wr_t                     o_buf_wr;
    logic [`GFP_PACK_ADDR_W-1:0] o_pack_rd_addr;
    rd_line_u                    i_pack_rd_data;
    exp_wr_t                     o_exp_wr;
    logic                        o_done;

    // ========================================
    // Reference model state
    // ========================================
    logic                        active;
    logic                        started;
    logic [`GFP_LINE_ADDR_W-1:0] cur_start;
    logic                        cur_target;
    int                          req_count;
    int                          wr_count;
    int                          exp_count;
    int                          accept_count;
    int                          done_count;
    int                          cycle_count = 0;
    rd_req_t                     exp_req;
    buf_wr_t                     exp_buf;
    exp_wr_t                     exp_exp;

    // Buffer model holds one block per target
    rd_line_u                    buf_mem [2][`GFP_BLOCK_LINES];
    rd_line_u                    pack_next;

    gfp_fetcher dut (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_cmd_valid    (i_cmd_valid),
        .o_cmd_ready    (o_cmd_ready),
        .i_cmd          (i_cmd),
        .o_req_valid    (o_req_valid),
        .i_req_ready    (i_req_ready),
        .o_req          (o_req),
        .i_beat_valid   (i_beat_valid),
        .o_beat_ready   (o_beat_ready),
        .i_beat         (i_beat),
        .o_buf_wr       (o_buf_wr),
        .o_pack_rd_addr (o_pack_rd_addr),
        .i_pack_rd_data (i_pack_rd_data),
        .o_exp_wr       (o_exp_wr),
        .o_done         (o_done)
    );

    initial begin
        i_clk = 1'b0;
    end

    always #4 i_clk = ~i_clk;

    // ========================================
    // Line pattern and expected values
    // ========================================
    // Every bit of the line number feeds all eight words
    function automatic logic [`GFP_LINE_W-1:0] line_pattern(
        input logic [`GFP_LINE_ADDR_W-1:0] line
    );
        logic [`GFP_LINE_W-1:0] pat;
        logic [31:0]            h;
        h = 32'(line) ^ 32'h5bd1e995;
        for (int k = 0; k < 8; k++) begin
            h = h * 32'h9e3779b1 + 32'(k);
            h = h ^ (h >> 15);
            pat[k*32 +: 32] = h;
        end
        return pat;
    endfunction

    // Exponent i is byte i mod 32 of packed line i div 32
    function automatic logic [`GFP_EXP_W-1:0] expected_exponent(
        input logic [`GFP_LINE_ADDR_W-1:0] start,
        input int                          idx
    );
        logic [`GFP_LINE_W-1:0] pat;
        pat = line_pattern(start + `GFP_LINE_ADDR_W'(idx / `GFP_EXP_PER_LINE));
        return pat[(idx % `GFP_EXP_PER_LINE) * `GFP_EXP_W +: `GFP_EXP_W];
    endfunction

    // ========================================
    // Compare tasks
    // ========================================
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            report_failure($sformatf("[FAIL] %s: expected %h, got %h", name, expected, got));
        end
    endtask

    task automatic check_req(input rd_req_t got, input rd_req_t expected);
        if (got !== expected) begin
            report_failure($sformatf("[FAIL] o_req: expected %h, got %h", expected, got));
        end
    endtask

    task automatic check_buf(input buf_wr_t got, input buf_wr_t expected);
        if (got !== expected) begin
            report_failure($sformatf("[FAIL] o_buf_wr: expected %h, got %h", expected, got));
        end
    endtask

    task automatic check_exp(input exp_wr_t got, input exp_wr_t expected);
        if (got !== expected) begin
            report_failure($sformatf("[FAIL] o_exp_wr: expected %h, got %h", expected, got));
        end
    endtask

    // Hang guard
    always @(posedge i_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            report_failure("Timeout: the fetcher hung before all commands completed");
        end
    end

    // ========================================
    // Monitor and buffer model at mid-cycle
    // ========================================
    always @(negedge i_clk) begin
        if (i_reset_n) begin
            // Read happens before write as in a registered RAM
            pack_next = buf_mem[cur_target][o_pack_rd_addr];
            if (o_buf_wr.en && o_buf_wr.addr < `GFP_BLOCK_LINES) begin
                buf_mem[o_buf_wr.target][o_buf_wr.addr] = o_buf_wr.data;
            end
            // Quiet outputs until the first command
            if (!started) begin
                check_flag("o_cmd_ready", o_cmd_ready, 1'b1);
                check_flag("o_req_valid", o_req_valid, 1'b0);
                check_flag("o_done", o_done, 1'b0);
                check_flag("o_buf_wr.en", o_buf_wr.en, 1'b0);
                check_flag("o_exp_wr.en", o_exp_wr.en, 1'b0);
            end
            if (!active && (o_req_valid || o_buf_wr.en || o_exp_wr.en)) begin
                report_failure("A read request or write appeared with no command in flight");
            end
            // Request for burst b carries page, pad, start + 16*b and zero byte bits
            if (active && o_req_valid && i_req_ready) begin
                if (req_count >= REQS) begin
                    report_failure("More than 33 read requests for one command");
                end
                exp_req = {`GFP_PAGE_ID, 2'b00,
                           cur_start + `GFP_LINE_ADDR_W'(req_count * `GFP_BURST_BEATS),
                           5'b00000};
                check_req(o_req, exp_req);
                req_count++;
            end
            if (active && o_buf_wr.en) begin
                if (wr_count >= `GFP_BLOCK_LINES) begin
                    report_failure("More than 528 buffer writes for one command");
                end
                exp_buf.en       = 1'b1;
                exp_buf.target   = cur_target;
                exp_buf.addr     = `GFP_BUF_ADDR_W'(wr_count);
                exp_buf.data.man = line_pattern(cur_start + `GFP_LINE_ADDR_W'(wr_count));
                check_buf(o_buf_wr, exp_buf);
                wr_count++;
            end
            if (active && o_exp_wr.en) begin
                if (exp_count >= EXPS) begin
                    report_failure("More than 512 exponent writes for one command");
                end
                exp_exp.en     = 1'b1;
                exp_exp.target = cur_target;
                exp_exp.addr   = `GFP_EXP_ADDR_W'(exp_count);
                exp_exp.data   = expected_exponent(cur_start, exp_count);
                check_exp(o_exp_wr, exp_exp);
                exp_count++;
            end
            // Done must follow every write and ready comes back with it
            if (o_done) begin
                if (!active) begin
                    report_failure("o_done pulsed with no command in flight");
                end
                if (req_count != REQS || wr_count != `GFP_BLOCK_LINES || exp_count != EXPS) begin
                    report_failure($sformatf("o_done came early after %0d requests, %0d %s",
                                             req_count, wr_count,
                                             $sformatf("line writes, %0d exponent writes",
                                                       exp_count)));
                end
                check_flag("o_cmd_ready", o_cmd_ready, 1'b1);
                active = 1'b0;
                done_count++;
            end else if (active) begin
                check_flag("o_cmd_ready", o_cmd_ready, 1'b0);
            end
            // Handshake completes at the coming edge
            if (i_cmd_valid && o_cmd_ready) begin
                active     = 1'b1;
                started    = 1'b1;
                cur_start  = i_cmd.line_addr;
                cur_target = i_cmd.target;
                req_count  = 0;
                wr_count   = 0;
                exp_count  = 0;
                accept_count++;
            end
        end
    end

    // Packed read data arrives one cycle after the address
    always @(posedge i_clk) begin
        #1;
        i_pack_rd_data = pack_next;
    end

    // ========================================
    // Memory model serving one burst at a time
    // ========================================
    initial begin : memory_model
        logic [`GFP_LINE_ADDR_W-1:0] base;
        wait (i_reset_n === 1'b1);
        forever begin
            @(posedge i_clk);
            #1;
            if (o_req_valid) begin
                // Request stall 0 to 3 cycles
                repeat ($urandom_range(0, 3)) begin
                    @(posedge i_clk);
                    #1;
                end
                i_req_ready = 1'b1;
                base        = o_req.line_addr;
                @(posedge i_clk);
                #1;
                i_req_ready = 1'b0;
                for (int b = 0; b < `GFP_BURST_BEATS; b++) begin
                    repeat ($urandom_range(0, 3)) begin
                        @(posedge i_clk);
                        #1;
                    end
                    if (!o_beat_ready) begin
                        report_failure("Beat ready was low in the middle of a read burst");
                    end
                    i_beat_valid     = 1'b1;
                    i_beat.data.man  = line_pattern(base + `GFP_LINE_ADDR_W'(b));
                    i_beat.last      = (b == `GFP_BURST_BEATS - 1);
                    @(posedge i_clk);
                    #1;
                    i_beat_valid = 1'b0;
                    i_beat.last  = 1'b0;
                end
            end
        end
    end

    // ========================================
    // Command stimulus
    // ========================================
    task automatic drive_random_command();
        i_cmd_valid      = 1'b1;
        i_cmd.line_addr  = `GFP_LINE_ADDR_W'($urandom);
        i_cmd.target     = 1'($urandom_range(0, 1));
    endtask

    initial begin
        void'($urandom(32'hc5b6001d));
        i_reset_n      = 1'b0;
        i_cmd_valid    = 1'b0;
        i_cmd          = '0;
        i_req_ready    = 1'b0;
        i_beat_valid   = 1'b0;
        i_beat         = '0;
        i_pack_rd_data = '0;
        pack_next      = '0;
        active         = 1'b0;
        started        = 1'b0;
        cur_start      = '0;
        cur_target     = 1'b0;
        req_count      = 0;
        wr_count       = 0;
        exp_count      = 0;
        accept_count   = 0;
        done_count     = 0;
        repeat (10) @(posedge i_clk);
        #1;
        i_reset_n = 1'b1;
        // Idle gap lets the reset-state checks run
        repeat ($urandom_range(2, 6)) begin
            @(posedge i_clk);
            #1;
        end
        // Next command waits with valid high while the current one runs
        for (int n = 0; n < NUM_CMDS; n++) begin
            drive_random_command();
            while (accept_count == n) begin
                @(posedge i_clk);
                #1;
            end
        end
        i_cmd_valid = 1'b0;
        while (done_count < NUM_CMDS) begin
            @(posedge i_clk);
            #1;
        end
        // Quiet tail catches stray writes or a second done
        repeat (20) begin
            @(posedge i_clk);
            #1;
        end
        // Slot must be free again after the last done
        if (o_cmd_ready === 1'b1 && !active && done_count == NUM_CMDS) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            report_failure("The fetcher did not return to idle after the last command");
        end
    end

endmodule : tb_gfp_fetcher

`default_nettype wire

// File: verilog/burst_reader.sv
// Read burst sequencer with request issue, beat counting, phase FSM and buffer writes
`default_nettype none

`include "gfp_fetch_params.svh"

module burst_reader
    import gfp_fetch_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_reset_n,

    // Job from decode
    input  wire logic       i_start,
    input  wire fetch_job_t i_job,

    // Read request channel
    output logic            o_req_valid,
    input  wire logic       i_req_ready,
    output rd_req_t         o_req,

    // Read data channel
    input  wire logic       i_beat_valid,
    output logic            o_beat_ready,
    input  wire rd_beat_t   i_beat,

    // Buffer write and stage pulses
    output buf_wr_t         o_buf_wr,
    output logic            o_exp_ready,
    output logic            o_finished
);

    // ========================================
    // Phase FSM
    // ========================================
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_REQ  = 2'd1,
        ST_EXP  = 2'd2,
        ST_MAN  = 2'd3
    } phase_t;

    phase_t                      state_q;
    logic                        req_valid_q;
    logic [5:0]                  burst_cnt_q;
    logic [`GFP_BUF_ADDR_W-1:0]  line_cnt_q;

    // Registered buffer write
    logic                        wr_en_q;
    logic                        wr_target_q;
    logic [`GFP_BUF_ADDR_W-1:0]  wr_addr_q;
    rd_line_u                    wr_data_q;

    logic                        exp_ready_q;
    logic                        finished_q;

    logic                        req_fire;
    logic                        beat_fire;
    logic                        last_line;
    logic [`GFP_LINE_ADDR_W-1:0] req_line;
    logic [`GFP_MEM_ADDR_W-1:0]  req_addr;

    assign req_fire  = req_valid_q & i_req_ready;
    assign beat_fire = i_beat_valid & o_beat_ready;
    // 528th line of the block closes the fetch
    assign last_line = (line_cnt_q == `GFP_BUF_ADDR_W'(`GFP_BLOCK_LINES - 1));

    // ========================================
    // Request address
    // ========================================
    // Burst b reads 16 lines starting at start + 16*b
    assign req_line = i_job.line_addr
                    + `GFP_LINE_ADDR_W'(burst_cnt_q) * `GFP_LINE_ADDR_W'(`GFP_BURST_BEATS);
    assign req_addr = {`GFP_PAGE_ID, 2'b00, req_line, 5'b00000};

    assign o_req_valid  = req_valid_q;
    assign o_req        = req_addr;
    // Beats are accepted for the whole burst and memory throttles with valid
    assign o_beat_ready = (state_q == ST_EXP) || (state_q == ST_MAN);

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state_q     <= ST_IDLE;
            req_valid_q <= 1'b0;
            burst_cnt_q <= '0;
            line_cnt_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (i_start) begin
                        state_q     <= ST_REQ;
                        req_valid_q <= 1'b1;
                        burst_cnt_q <= '0;
                        line_cnt_q  <= '0;
                    end
                end

                ST_REQ: begin
                    if (req_fire) begin
                        req_valid_q <= 1'b0;
                        // First burst carries the packed exponents
                        state_q     <= (burst_cnt_q == '0) ? ST_EXP : ST_MAN;
                    end
                end

                ST_EXP, ST_MAN: begin
                    if (beat_fire) begin
                        line_cnt_q <= line_cnt_q + 1'b1;
                        if (i_beat.last) begin
                            burst_cnt_q <= burst_cnt_q + 1'b1;
                            if (last_line) begin
                                state_q <= ST_IDLE;
                            end else begin
                                // Next burst goes out right after last
                                state_q     <= ST_REQ;
                                req_valid_q <= 1'b1;
                            end
                        end
                    end
                end

                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // ========================================
    // Buffer write and pulses
    // ========================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            wr_en_q     <= 1'b0;
            exp_ready_q <= 1'b0;
            finished_q  <= 1'b0;
        end else begin
            wr_en_q     <= beat_fire;
            // Exponent lines complete with the last beat of burst 0
            exp_ready_q <= beat_fire && (state_q == ST_EXP)
                        && (line_cnt_q == `GFP_BUF_ADDR_W'(`GFP_EXP_LINES - 1));
            finished_q  <= beat_fire && last_line;
        end
    end

    // Write payload follows the beat and the line number is the buffer address
    always_ff @(posedge i_clk) begin
        if (beat_fire) begin
            wr_addr_q   <= line_cnt_q;
            wr_data_q   <= i_beat.data;
            wr_target_q <= i_job.target;
        end
    end

    assign o_buf_wr.en     = wr_en_q;
    assign o_buf_wr.target = wr_target_q;
    assign o_buf_wr.addr   = wr_addr_q;
    assign o_buf_wr.data   = wr_data_q;

    assign o_exp_ready = exp_ready_q;
    assign o_finished  = finished_q;

endmodule : burst_reader

`default_nettype wire

// File: verilog/exp_unpacker.sv
// Exponent unpacker: reads packed lines back and writes one exponent per cycle
`default_nettype none

`include "gfp_fetch_params.svh"

module exp_unpacker
    import gfp_fetch_pkg::*;
(
    input  wire logic                        i_clk,
    input  wire logic                        i_reset_n,

    // Start from the reader once all packed lines are in the buffer
    input  wire logic                        i_start_unpack,
    input  wire fetch_job_t                  i_job,

    // Packed-line read port, data one cycle after the address
    output logic [`GFP_PACK_ADDR_W-1:0]      o_pack_rd_addr,
    input  wire rd_line_u                    i_pack_rd_data,

    // Single exponent writes
    output exp_wr_t                          o_exp_wr,
    output logic                             o_finished
);

    // ========================================
    // Index counter
    // ========================================
    logic                       running_q;
    logic [9:0]                 idx_q;
    logic                       last_idx;

    // Read stage, aligned with returned data
    logic                       wr_valid_q;
    logic                       wr_last_q;
    logic [`GFP_EXP_ADDR_W-1:0] wr_idx_q;

    assign last_idx = (idx_q == 10'(`GFP_MAN_LINES - 1));

    // Free-running once started, no stall on mantissa traffic
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            running_q <= 1'b0;
            idx_q     <= '0;
        end else if (i_start_unpack) begin
            running_q <= 1'b1;
            idx_q     <= '0;
        end else if (running_q) begin
            idx_q <= idx_q + 1'b1;
            if (last_idx) begin
                running_q <= 1'b0;
            end
        end
    end

    // 32 exponents per line: index / 32 picks the packed line
    assign o_pack_rd_addr = idx_q[`GFP_EXP_ADDR_W-1:5];

    // ========================================
    // Write stage
    // ========================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            wr_valid_q <= 1'b0;
            wr_last_q  <= 1'b0;
        end else begin
            wr_valid_q <= running_q;
            wr_last_q  <= running_q && last_idx;
        end
    end

    // Delayed index follows the read latency
    always_ff @(posedge i_clk) begin
        wr_idx_q <= idx_q[`GFP_EXP_ADDR_W-1:0];
    end

    // Byte select through the exponent view of the line
    assign o_exp_wr.en     = wr_valid_q;
    assign o_exp_wr.target = i_job.target;
    assign o_exp_wr.addr   = wr_idx_q;
    assign o_exp_wr.data   = i_pack_rd_data.exps[wr_idx_q[4:0]];

    // Finished rides with the 512th write
    assign o_finished = wr_last_q;

endmodule : exp_unpacker

`default_nettype wire

// File: verilog/fetch_cmd_decode.sv
// Command handshake, active job register and completion tracking with done pulse
`default_nettype none

module fetch_cmd_decode
    import gfp_fetch_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_reset_n,

    // Command handshake
    input  wire logic       i_cmd_valid,
    output logic            o_cmd_ready,
    input  wire fetch_cmd_t i_cmd,

    // Completion pulses from the two stages
    input  wire logic       i_rd_finished,
    input  wire logic       i_unpack_finished,

    // Job to the stages
    output logic            o_start,
    output fetch_job_t      o_job,
    output logic            o_done
);

    logic       busy_q;
    logic       start_q;
    logic       done_q;
    logic       rd_seen_q;
    logic       unpack_seen_q;
    logic       accept;
    logic       rd_seen;
    logic       unpack_seen;
    fetch_job_t job_q;

    // ========================================
    // Handshake
    // ========================================
    // Ready only while idle, so a held command is taken once
    assign o_cmd_ready = ~busy_q;
    assign accept      = i_cmd_valid & ~busy_q;

    // A pulse in this cycle counts as already seen
    assign rd_seen     = rd_seen_q | i_rd_finished;
    assign unpack_seen = unpack_seen_q | i_unpack_finished;

    // ========================================
    // Control state
    // ========================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            busy_q        <= 1'b0;
            start_q       <= 1'b0;
            done_q        <= 1'b0;
            rd_seen_q     <= 1'b0;
            unpack_seen_q <= 1'b0;
        end else begin
            start_q <= accept;
            done_q  <= 1'b0;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (busy_q && rd_seen && unpack_seen) begin
                // Both stages are through: pulse done and free the slot
                busy_q        <= 1'b0;
                done_q        <= 1'b1;
                rd_seen_q     <= 1'b0;
                unpack_seen_q <= 1'b0;
            end else begin
                rd_seen_q     <= rd_seen;
                unpack_seen_q <= unpack_seen;
            end
        end
    end

    // Job payload, captured at acceptance
    always_ff @(posedge i_clk) begin
        if (accept) begin
            job_q <= i_cmd;
        end
    end

    assign o_start = start_q;
    assign o_job   = job_q;
    assign o_done  = done_q;

endmodule : fetch_cmd_decode

`default_nettype wire

// File: verilog/gfp_fetch_params.svh
// GFP8 block fetch sizes: line counts, widths, burst length and memory page
`ifndef GFP_FETCH_PARAMS_SVH
`define GFP_FETCH_PARAMS_SVH

// ========================================
// Line and exponent widths
// ========================================
`define GFP_LINE_W        256
`define GFP_EXP_W         8
`define GFP_EXP_PER_LINE  32

// ========================================
// Block layout
// ========================================
// Packed exponent lines come first, mantissas after them
`define GFP_EXP_LINES     16
`define GFP_MAN_LINES     512
`define GFP_BLOCK_LINES   528
`define GFP_BURST_BEATS   16

// Address widths
`define GFP_BUF_ADDR_W    11
`define GFP_EXP_ADDR_W    9
`define GFP_PACK_ADDR_W   4
`define GFP_LINE_ADDR_W   26

// Memory request: page id routes the request to the right channel
`define GFP_PAGE_ID       9'd2
`define GFP_MEM_ADDR_W    42

`endif

// File: verilog/gfp_fetch_pkg.sv
// Shared types: fetch command, job, read request, read beat, buffer and exponent writes
`default_nettype none

`include "gfp_fetch_params.svh"

package gfp_fetch_pkg;

    // ========================================
    // Command side
    // ========================================
    // Target 0 is the left buffer, 1 the right one
    typedef struct packed {
        logic [`GFP_LINE_ADDR_W-1:0] line_addr;
        logic                        target;
    } fetch_cmd_t;

    // Accepted command, held for the whole fetch
    typedef struct packed {
        logic [`GFP_LINE_ADDR_W-1:0] line_addr;
        logic                        target;
    } fetch_job_t;

    // ========================================
    // Memory side
    // ========================================
    // Byte address of a line, high to low
    typedef struct packed {
        logic [8:0]                  page_id;
        logic [1:0]                  pad;
        logic [`GFP_LINE_ADDR_W-1:0] line_addr;
        logic [4:0]                  byte_sel;
    } rd_req_t;

    // One line, seen either as packed exponents or as a mantissa word
    // Exponent byte 0 sits in the lowest bits
    typedef union packed {
        logic [`GFP_EXP_PER_LINE-1:0][`GFP_EXP_W-1:0] exps;
        logic [`GFP_LINE_W-1:0]                       man;
    } rd_line_u;

    typedef struct packed {
        rd_line_u data;
        logic     last;
    } rd_beat_t;

    // ========================================
    // Buffer side
    // ========================================
    typedef struct packed {
        logic                       en;
        logic                       target;
        logic [`GFP_BUF_ADDR_W-1:0] addr;
        rd_line_u                   data;
    } buf_wr_t;

    typedef struct packed {
        logic                       en;
        logic                       target;
        logic [`GFP_EXP_ADDR_W-1:0] addr;
        logic [`GFP_EXP_W-1:0]      data;
    } exp_wr_t;

endpackage : gfp_fetch_pkg

`default_nettype wire

// File: verilog/gfp_fetcher.sv
// GFP8 block fetcher top: command decode, burst reader and exponent unpacker
`default_nettype none

`include "gfp_fetch_params.svh"

module gfp_fetcher
    import gfp_fetch_pkg::*;
(
    input  wire logic                   i_clk,
    input  wire logic                   i_reset_n,

    // ========================================
    // Command
    // ========================================
    input  wire logic                   i_cmd_valid,
    output logic                        o_cmd_ready,
    input  wire fetch_cmd_t             i_cmd,

    // ========================================
    // Memory read
    // ========================================
    output logic                        o_req_valid,
    input  wire logic                   i_req_ready,
    output rd_req_t                     o_req,
    input  wire logic                   i_beat_valid,
    output logic                        o_beat_ready,
    input  wire rd_beat_t               i_beat,

    // ========================================
    // Buffer side
    // ========================================
    output buf_wr_t                     o_buf_wr,
    output logic [`GFP_PACK_ADDR_W-1:0] o_pack_rd_addr,
    input  wire rd_line_u               i_pack_rd_data,
    output exp_wr_t                     o_exp_wr,

    output logic                        o_done
);

    logic       start;
    fetch_job_t job;
    logic       exp_ready;
    logic       rd_finished;
    logic       unpack_finished;

    // Handshake and completion
    fetch_cmd_decode u_decode (
        .i_clk             (i_clk),
        .i_reset_n         (i_reset_n),
        .i_cmd_valid       (i_cmd_valid),
        .o_cmd_ready       (o_cmd_ready),
        .i_cmd             (i_cmd),
        .i_rd_finished     (rd_finished),
        .i_unpack_finished (unpack_finished),
        .o_start           (start),
        .o_job             (job),
        .o_done            (o_done)
    );

    // Memory to buffer
    burst_reader u_reader (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_start      (start),
        .i_job        (job),
        .o_req_valid  (o_req_valid),
        .i_req_ready  (i_req_ready),
        .o_req        (o_req),
        .i_beat_valid (i_beat_valid),
        .o_beat_ready (o_beat_ready),
        .i_beat       (i_beat),
        .o_buf_wr     (o_buf_wr),
        .o_exp_ready  (exp_ready),
        .o_finished   (rd_finished)
    );

    // Unpacking overlaps the mantissa bursts
    exp_unpacker u_unpacker (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_start_unpack (exp_ready),
        .i_job          (job),
        .o_pack_rd_addr (o_pack_rd_addr),
        .i_pack_rd_data (i_pack_rd_data),
        .o_exp_wr       (o_exp_wr),
        .o_finished     (unpack_finished)
    );

endmodule : gfp_fetcher

`default_nettype wire
